// ==== mips_pkg.sv ====
package mips_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and sizes
    ////////////////////////////////////////////////////////////////////////////

    // Datapath word
    localparam int DATA_W      = 32;

    // Register file
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 32;

    // Data memory, word addressed
    localparam int DMEM_WORDS  = 64;
    localparam int DMEM_ADDR_W = 6;

    // Instruction fields
    localparam int OPCODE_W    = 6;
    localparam int FUNCT_W     = 6;
    localparam int IMM_W       = 16;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction codes
    ////////////////////////////////////////////////////////////////////////////

    // Primary opcodes, instr[31:26]
    localparam logic [OPCODE_W-1:0] OP_RTYPE = 6'h00;
    localparam logic [OPCODE_W-1:0] OP_ADDI  = 6'h08;
    localparam logic [OPCODE_W-1:0] OP_ANDI  = 6'h0c;
    localparam logic [OPCODE_W-1:0] OP_ORI   = 6'h0d;
    localparam logic [OPCODE_W-1:0] OP_LUI   = 6'h0f;
    localparam logic [OPCODE_W-1:0] OP_LW    = 6'h23;
    localparam logic [OPCODE_W-1:0] OP_SW    = 6'h2b;

    // R-type function codes, instr[5:0]
    localparam logic [FUNCT_W-1:0]  FN_ADD   = 6'h20;
    localparam logic [FUNCT_W-1:0]  FN_SUB   = 6'h22;
    localparam logic [FUNCT_W-1:0]  FN_AND   = 6'h24;
    localparam logic [FUNCT_W-1:0]  FN_OR    = 6'h25;
    localparam logic [FUNCT_W-1:0]  FN_SLT   = 6'h2a;

    ////////////////////////////////////////////////////////////////////////////
    // ALU operations
    ////////////////////////////////////////////////////////////////////////////

    localparam int ALU_OP_W = 3;

    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 3'd4;
    // Immediate into the upper half, low half cleared
    localparam logic [ALU_OP_W-1:0] ALU_LUI  = 3'd5;

endpackage

// ==== reg_file.sv ====
`timescale 1ns/10ps

module reg_file
    import mips_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_we,
    input  logic [REG_ADDR_W-1:0] i_rs_idx,
    input  logic [REG_ADDR_W-1:0] i_rt_idx,
    input  logic [REG_ADDR_W-1:0] i_rd_idx,
    input  logic [DATA_W-1:0]     i_wdata,
    output logic [DATA_W-1:0]     o_rs_data,
    output logic [DATA_W-1:0]     o_rt_data
);

    logic [DATA_W-1:0] regs [NUM_REGS];
    logic              rst_q;

    ////////////////////////////////////////////////////////////////////////////
    // Reset and write
    ////////////////////////////////////////////////////////////////////////////

    // Reset taken on the rising edge like the rest of the core
    always_ff @(posedge i_clk)
    begin
        rst_q <= i_rst;
    end

    // Array is owned by the falling edge, so the clear lands half a cycle later
    always_ff @(negedge i_clk)
    begin
        if (rst_q)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_we && (i_rd_idx != '0))
        begin
            regs[i_rd_idx] <= i_wdata;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////////////////////////////

    // $0 is hardwired
    always_comb
    begin
        o_rs_data = (i_rs_idx == '0) ? '0 : regs[i_rs_idx];
        o_rt_data = (i_rt_idx == '0) ? '0 : regs[i_rt_idx];
    end

endmodule

// ==== ctrl_decoder.sv ====
`timescale 1ns/10ps

module ctrl_decoder
    import mips_pkg::*;
(
    input  logic [DATA_W-1:0]   i_instr,
    output logic [ALU_OP_W-1:0] o_alu_op,
    output logic                o_use_imm,
    output logic                o_zero_ext,
    output logic                o_rd_is_rt,
    output logic                o_reg_write,
    output logic                o_mem_read,
    output logic                o_mem_write,
    output logic                o_illegal
);

    logic [OPCODE_W-1:0] opcode;
    logic [FUNCT_W-1:0]  funct;

    assign opcode = i_instr[DATA_W-1 -: OPCODE_W];
    assign funct  = i_instr[FUNCT_W-1:0];

    always_comb
    begin
        // Safe defaults, nothing written
        o_alu_op    = ALU_ADD;
        o_use_imm   = 1'b0;
        o_zero_ext  = 1'b0;
        o_rd_is_rt  = 1'b0;
        o_reg_write = 1'b0;
        o_mem_read  = 1'b0;
        o_mem_write = 1'b0;
        o_illegal   = 1'b0;

        case (opcode)
            OP_RTYPE:
            begin
                o_reg_write = 1'b1;
                case (funct)
                    FN_ADD:  o_alu_op = ALU_ADD;
                    FN_SUB:  o_alu_op = ALU_SUB;
                    FN_AND:  o_alu_op = ALU_AND;
                    FN_OR:   o_alu_op = ALU_OR;
                    FN_SLT:  o_alu_op = ALU_SLT;
                    default:
                    begin
                        o_reg_write = 1'b0;
                        o_illegal   = 1'b1;
                    end
                endcase
            end
            OP_ADDI:
            begin
                o_use_imm   = 1'b1;
                o_rd_is_rt  = 1'b1;
                o_reg_write = 1'b1;
            end
            // Logical immediates are zero-extended
            OP_ANDI, OP_ORI:
            begin
                o_alu_op    = (opcode == OP_ANDI) ? ALU_AND : ALU_OR;
                o_use_imm   = 1'b1;
                o_zero_ext  = 1'b1;
                o_rd_is_rt  = 1'b1;
                o_reg_write = 1'b1;
            end
            // ALU only needs the raw 16 bits
            OP_LUI:
            begin
                o_alu_op    = ALU_LUI;
                o_use_imm   = 1'b1;
                o_zero_ext  = 1'b1;
                o_rd_is_rt  = 1'b1;
                o_reg_write = 1'b1;
            end
            OP_LW:
            begin
                o_use_imm   = 1'b1;
                o_rd_is_rt  = 1'b1;
                o_reg_write = 1'b1;
                o_mem_read  = 1'b1;
            end
            // Address goes out as the result, no register write
            OP_SW:
            begin
                o_use_imm   = 1'b1;
                o_mem_write = 1'b1;
            end
            default:
            begin
                o_illegal = 1'b1;
            end
        endcase
    end

endmodule

// ==== alu.sv ====
`timescale 1ns/10ps

module alu
    import mips_pkg::*;
(
    input  logic [ALU_OP_W-1:0] i_op,
    input  logic [DATA_W-1:0]   i_a,
    input  logic [DATA_W-1:0]   i_b,
    output logic [DATA_W-1:0]   o_y
);

    logic [DATA_W-1:0] sum;
    logic [DATA_W-1:0] diff;
    logic              less;

    ////////////////////////////////////////////////////////////////////////////
    // Arithmetic
    ////////////////////////////////////////////////////////////////////////////

    // Carry out and overflow simply drop off
    assign sum  = i_a + i_b;
    assign diff = i_a - i_b;

    // Signed compare for slt
    assign less = ($signed(i_a) < $signed(i_b));

    ////////////////////////////////////////////////////////////////////////////
    // Result select
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (i_op)
            ALU_ADD:
            begin
                o_y = sum;
            end
            ALU_SUB:
            begin
                o_y = diff;
            end
            ALU_AND:
            begin
                o_y = i_a & i_b;
            end
            ALU_OR:
            begin
                o_y = i_a | i_b;
            end
            ALU_SLT:
            begin
                o_y = {{(DATA_W-1){1'b0}}, less};
            end
            // Low half of B moves up, low half cleared
            ALU_LUI:
            begin
                o_y = {i_b[IMM_W-1:0], {(DATA_W-IMM_W){1'b0}}};
            end
            default:
            begin
                o_y = '0;
            end
        endcase
    end

endmodule

// ==== data_mem.sv ====
`timescale 1ns/10ps

module data_mem
    import mips_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_we,
    input  logic [DMEM_ADDR_W-1:0] i_addr,
    input  logic [DATA_W-1:0]      i_wdata,
    output logic [DATA_W-1:0]      o_rdata
);

    logic [DATA_W-1:0] mem [DMEM_WORDS];

    ////////////////////////////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            // Whole array back to zero
            for (int i = 0; i < DMEM_WORDS; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (i_we)
        begin
            mem[i_addr] <= i_wdata;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read port
    ////////////////////////////////////////////////////////////////////////////

    // Asynchronous read, lw data is ready in the same cycle
    assign o_rdata = mem[i_addr];

endmodule

// ==== exec_sequencer.sv ====
`timescale 1ns/10ps

module exec_sequencer
    import mips_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_req,
    input  logic [DATA_W-1:0] i_instr,
    input  logic [DATA_W-1:0] i_wb_value,
    input  logic              i_illegal,
    output logic [DATA_W-1:0] o_instr,
    output logic              o_exec,
    output logic              o_wb,
    output logic [DATA_W-1:0] o_result,
    output logic              o_illegal,
    output logic              o_ack
);

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_EXEC,
        ST_WB,
        ST_ACK
    } state_t;

    state_t state;

    ////////////////////////////////////////////////////////////////////////////
    // Handshake FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            state     <= ST_IDLE;
            o_result  <= '0;
            o_illegal <= 1'b0;
            o_ack     <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (i_req)
                    begin
                        state <= ST_EXEC;
                    end
                end
                // Result captured here, sw writes memory on this edge too
                ST_EXEC:
                begin
                    o_result  <= i_illegal ? '0 : i_wb_value;
                    o_illegal <= i_illegal;
                    state     <= ST_WB;
                end
                // Register file wrote on the falling edge of this cycle
                ST_WB:
                begin
                    o_ack <= 1'b1;
                    state <= ST_ACK;
                end
                ST_ACK:
                begin
                    // Hold until the host lets go
                    if (!i_req)
                    begin
                        o_ack <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Instruction word, stable for the rest of the transaction
    always_ff @(posedge i_clk)
    begin
        if ((state == ST_IDLE) && i_req)
        begin
            o_instr <= i_instr;
        end
    end

    // One-cycle strobes straight from the state
    assign o_exec = (state == ST_EXEC);
    assign o_wb   = (state == ST_WB);

endmodule

// ==== mips_exec_top.sv ====
`timescale 1ns/10ps

module mips_exec_top
    import mips_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_req,
    input  logic [DATA_W-1:0] i_instr,
    output logic              o_ack,
    output logic [DATA_W-1:0] o_result,
    output logic              o_illegal
);

    logic [DATA_W-1:0]     instr;
    logic                  s_exec;
    logic                  s_wb;
    logic [ALU_OP_W-1:0]   alu_op;
    logic                  use_imm;
    logic                  zero_ext;
    logic                  rd_is_rt;
    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    logic                  dec_illegal;
    logic [DATA_W-1:0]     rs_data;
    logic [DATA_W-1:0]     rt_data;
    logic [DATA_W-1:0]     imm_ext;
    logic [DATA_W-1:0]     alu_b;
    logic [DATA_W-1:0]     alu_y;
    logic [DATA_W-1:0]     mem_rdata;
    logic [DATA_W-1:0]     wb_value;
    logic [REG_ADDR_W-1:0] wr_idx;

    ////////////////////////////////////////////////////////////////////////////
    // Glue
    ////////////////////////////////////////////////////////////////////////////

    // Immediate extension, sign unless the decoder says otherwise
    assign imm_ext  = zero_ext ? {{(DATA_W-IMM_W){1'b0}}, instr[IMM_W-1:0]}
                               : {{(DATA_W-IMM_W){instr[IMM_W-1]}}, instr[IMM_W-1:0]};
    assign alu_b    = use_imm ? imm_ext : rt_data;
    // I-types write rt, R-types write rd
    assign wr_idx   = rd_is_rt ? instr[20:16] : instr[15:11];
    assign wb_value = mem_read ? mem_rdata : alu_y;

    ////////////////////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////////////////////

    exec_sequencer u_seq (
        .i_clk(i_clk), .i_rst(i_rst), .i_req(i_req), .i_instr(i_instr),
        .i_wb_value(wb_value), .i_illegal(dec_illegal), .o_instr(instr),
        .o_exec(s_exec), .o_wb(s_wb), .o_result(o_result),
        .o_illegal(o_illegal), .o_ack(o_ack)
    );

    ctrl_decoder u_dec (
        .i_instr(instr), .o_alu_op(alu_op), .o_use_imm(use_imm),
        .o_zero_ext(zero_ext), .o_rd_is_rt(rd_is_rt), .o_reg_write(reg_write),
        .o_mem_read(mem_read), .o_mem_write(mem_write), .o_illegal(dec_illegal)
    );

    reg_file u_regs (
        .i_clk(i_clk), .i_rst(i_rst), .i_we(reg_write & s_wb),
        .i_rs_idx(instr[25:21]), .i_rt_idx(instr[20:16]), .i_rd_idx(wr_idx),
        .i_wdata(wb_value), .o_rs_data(rs_data), .o_rt_data(rt_data)
    );

    alu u_alu (.i_op(alu_op), .i_a(rs_data), .i_b(alu_b), .o_y(alu_y));

    // Byte address in, word index from bits 7:2
    data_mem u_dmem (
        .i_clk(i_clk), .i_rst(i_rst), .i_we(mem_write & s_exec),
        .i_addr(alu_y[DMEM_ADDR_W+1:2]), .i_wdata(rt_data), .o_rdata(mem_rdata)
    );

endmodule

// ==== tb_mips_exec.sv ====
`timescale 1ns/10ps

module tb_mips_exec
    import mips_pkg::*;
();

    localparam int N_RAND   = 30;
    localparam int N_READ   = 15;
    localparam int ACK_WAIT = 16;

    logic              clk;
    logic              rst;
    logic              req;
    logic [DATA_W-1:0] instr;
    logic              ack;
    logic [DATA_W-1:0] result;
    logic              illegal;

    // Stimulus table with one entry per instruction
    logic [DATA_W-1:0]  tbl_instr [$];
    logic [DATA_W-1:0]  tbl_exp [$];
    logic               tbl_ill [$];
    // Reference state
    logic [DATA_W-1:0]  shadow_regs [NUM_REGS];
    logic [DATA_W-1:0]  shadow_mem [DMEM_WORDS];
    logic [FUNCT_W-1:0] funct_list [5] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT};

    int                 errors = 0;
    int                 hs_errors = 0;
    int                 cycles = 0;
    int                 cycle_limit = 100;
    logic [31:0]        rng = 32'd20475;

    mips_exec_top dut0 (
        .i_clk(clk), .i_rst(rst), .i_req(req), .i_instr(instr),
        .o_ack(ack), .o_result(result), .o_illegal(illegal)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Watchdog
    always @(posedge clk)
    begin
        cycles++;
        if (cycles > cycle_limit)
        begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("Checks failed: %0d value, %0d handshake", errors, hs_errors);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Encoding and random helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [DATA_W-1:0] enc_r(input logic [5:0] fn, input logic [4:0] rd,
                                               input logic [4:0] rs, input logic [4:0] rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [DATA_W-1:0] enc_i(input logic [5:0] op, input logic [4:0] rt,
                                               input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic add_entry(input logic [DATA_W-1:0] w, input logic [DATA_W-1:0] exp_res,
                             input logic exp_ill);
        tbl_instr.push_back(w);
        tbl_exp.push_back(exp_res);
        tbl_ill.push_back(exp_ill);
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] act);
        assert (act === exp)
        else
        begin
            errors++;
            $display("Fail at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic model_step(input logic [DATA_W-1:0] w, output logic [DATA_W-1:0] res,
                              output logic ill);
        logic [DATA_W-1:0]     a;
        logic [DATA_W-1:0]     b;
        logic [DATA_W-1:0]     addr;
        logic [REG_ADDR_W-1:0] dst;
        logic                  wr;
        a    = shadow_regs[w[25:21]];
        b    = shadow_regs[w[20:16]];
        addr = a + {{16{w[15]}}, w[15:0]};
        dst  = w[20:16];
        wr   = 1'b1;
        res  = '0;
        ill  = 1'b0;
        case (w[31:26])
            OP_RTYPE:
            begin
                dst = w[15:11];
                case (w[5:0])
                    FN_ADD:  res = a + b;
                    FN_SUB:  res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: ill = 1'b1;
                endcase
            end
            OP_ADDI: res = addr;
            OP_ANDI: res = a & {16'h0, w[15:0]};
            OP_ORI:  res = a | {16'h0, w[15:0]};
            OP_LUI:  res = {w[15:0], 16'h0};
            OP_LW:   res = shadow_mem[addr[7:2]];
            // Store reports its byte address
            OP_SW:
            begin
                res = addr;
                wr  = 1'b0;
                shadow_mem[addr[7:2]] = b;
            end
            default: ill = 1'b1;
        endcase
        if (wr && !ill && (dst != '0))
            shadow_regs[dst] = res;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Host side of the handshake
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_instr(input logic [DATA_W-1:0] w, input logic [DATA_W-1:0] exp_res,
                             input logic exp_ill, input int hold);
        int waited;
        waited = 0;
        @(negedge clk);
        instr = w;
        req   = 1'b1;
        while (!ack && (waited < ACK_WAIT))
        begin
            @(negedge clk);
            waited++;
        end
        assert (ack)
        else
        begin
            hs_errors++;
            $display("Handshake error at %0d ns: no ack for instruction %h", $time, w);
        end
        if (ack)
        begin
            check_value("o_result", exp_res, result);
            check_value("o_illegal", exp_ill, illegal);
            // Outputs must hold through a late release
            repeat (hold)
            begin
                @(negedge clk);
                check_value("o_ack", 1, ack);
                check_value("o_result", exp_res, result);
            end
        end
        req    = 1'b0;
        waited = 0;
        while (ack && (waited < ACK_WAIT))
        begin
            @(negedge clk);
            waited++;
        end
        assert (!ack)
        else
        begin
            hs_errors++;
            $display("Handshake error at %0d ns: o_ack stayed high after req fell", $time);
        end
    endtask

    task automatic random_instr(output logic [DATA_W-1:0] w, output int hold);
        logic [REG_ADDR_W-1:0] ra;
        logic [REG_ADDR_W-1:0] rb;
        logic [REG_ADDR_W-1:0] rc;
        logic [15:0]           imm;
        rng  = xorshift(rng);
        // Lower sixteen registers only so results get reused
        ra   = {1'b0, rng[3:0]};
        rb   = {1'b0, rng[7:4]};
        rc   = {1'b0, rng[11:8]};
        hold = rng[14:12] % 5;
        imm  = rng[31:16];
        rng  = xorshift(rng);
        case (rng % 7)
            0:       w = enc_i(OP_ADDI, ra, ra, imm);
            1:       w = enc_r(funct_list[rng[10:8] % 5], rc, ra, rb);
            2:       w = enc_i(OP_ORI, rc, ra, imm);
            3:       w = enc_i(OP_LUI, rc, 5'd0, imm);
            4:       w = enc_i(OP_SW, rb, 5'd0, {11'd0, rng[18:16], 2'b00});
            5:       w = enc_i(OP_LW, rc, 5'd0, {11'd0, rng[18:16], 2'b00});
            default: w = enc_i(OP_ANDI, rc, ra, imm);
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed table
    ////////////////////////////////////////////////////////////////////////////

    task automatic build_table();
        // Straight after reset
        add_entry(enc_r(FN_ADD, 3, 1, 2), 32'h0000_0000, 0);
        // Immediate loads
        add_entry(enc_i(OP_ADDI, 1, 0, 16'h0005), 32'h0000_0005, 0);
        add_entry(enc_i(OP_ADDI, 2, 0, 16'hfffd), 32'hffff_fffd, 0);
        add_entry(enc_i(OP_ORI, 3, 0, 16'hf0f0), 32'h0000_f0f0, 0);
        add_entry(enc_i(OP_ANDI, 4, 2, 16'h00ff), 32'h0000_00fd, 0);
        add_entry(enc_i(OP_LUI, 5, 0, 16'h1234), 32'h1234_0000, 0);
        add_entry(enc_i(OP_ORI, 5, 5, 16'h5678), 32'h1234_5678, 0);
        // R-type with $2 holding -3
        add_entry(enc_r(FN_ADD, 6, 1, 2), 32'h0000_0002, 0);
        add_entry(enc_r(FN_SUB, 7, 1, 2), 32'h0000_0008, 0);
        add_entry(enc_r(FN_AND, 8, 5, 3), 32'h0000_5070, 0);
        add_entry(enc_r(FN_OR, 9, 4, 3), 32'h0000_f0fd, 0);
        add_entry(enc_r(FN_SLT, 10, 2, 1), 32'h0000_0001, 0);
        add_entry(enc_r(FN_SLT, 11, 1, 2), 32'h0000_0000, 0);
        add_entry(enc_r(FN_SUB, 12, 2, 1), 32'hffff_fff8, 0);
        add_entry(enc_r(FN_SLT, 13, 12, 2), 32'h0000_0001, 0);
        // $0 as destination
        add_entry(enc_i(OP_ADDI, 0, 1, 16'h0007), 32'h0000_000c, 0);
        add_entry(enc_r(FN_ADD, 14, 0, 0), 32'h0000_0000, 0);
        // Destination doubles as source
        add_entry(enc_r(FN_ADD, 1, 1, 1), 32'h0000_000a, 0);
        add_entry(enc_i(OP_ADDI, 15, 1, 16'h0000), 32'h0000_000a, 0);
        // Store and load back
        add_entry(enc_i(OP_SW, 5, 0, 16'h0008), 32'h0000_0008, 0);
        add_entry(enc_i(OP_LW, 16, 0, 16'h0008), 32'h1234_5678, 0);
        add_entry(enc_i(OP_SW, 2, 1, 16'h0006), 32'h0000_0010, 0);
        add_entry(enc_i(OP_LW, 17, 0, 16'h0010), 32'hffff_fffd, 0);
        // Stores leave their rt registers alone
        add_entry(enc_r(FN_ADD, 20, 5, 2), 32'h1234_5675, 0);
        // Bad opcode and bad funct leave state unchanged
        add_entry(enc_i(6'h3f, 1, 2, 16'h0001), 32'h0000_0000, 1);
        add_entry(enc_r(6'h27, 1, 2, 3), 32'h0000_0000, 1);
        add_entry(enc_i(OP_ADDI, 18, 1, 16'h0000), 32'h0000_000a, 0);
        add_entry(enc_i(OP_LW, 19, 0, 16'h0008), 32'h1234_5678, 0);
    endtask

    initial
    begin : stimulus
        logic [DATA_W-1:0] w;
        logic [DATA_W-1:0] exp_res;
        logic              exp_ill;
        int                hold;
        rst   = 1'b1;
        req   = 1'b0;
        instr = '0;
        for (int i = 0; i < NUM_REGS; i++)
            shadow_regs[i] = '0;
        for (int i = 0; i < DMEM_WORDS; i++)
            shadow_mem[i] = '0;
        build_table();
        cycle_limit = 10 * (tbl_instr.size() + N_RAND + N_READ) + 100;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("o_ack", 0, ack);
        check_value("o_result", 0, result);
        check_value("o_illegal", 0, illegal);

        for (int i = 0; i < tbl_instr.size(); i++)
        begin
            model_step(tbl_instr[i], exp_res, exp_ill);
            run_instr(tbl_instr[i], tbl_exp[i], tbl_ill[i], 0);
        end

        // Random pass with late req release
        for (int i = 0; i < N_RAND; i++)
        begin
            random_instr(w, hold);
            model_step(w, exp_res, exp_ill);
            run_instr(w, exp_res, exp_ill, hold);
        end

        // Read back through or $0, $k, $0
        for (int k = 1; k <= N_READ; k++)
        begin
            w = enc_r(FN_OR, 0, k, 0);
            model_step(w, exp_res, exp_ill);
            run_instr(w, exp_res, exp_ill, 0);
        end

        $display("Checks failed: %0d value, %0d handshake", errors, hs_errors);
        if ((errors == 0) && (hs_errors == 0))
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== project.f ====
mips_pkg.sv
reg_file.sv
ctrl_decoder.sv
alu.sv
data_mem.sv
exec_sequencer.sv
mips_exec_top.sv
tb_mips_exec.sv
